// File: logic/div_pkg.sv
package div_pkg;

  // data path width of the execute stage
  localparam int unsigned XLEN = 64;
  // word width for the *W instruction forms
  localparam int unsigned WLEN = 32;
  // iteration counter, must hold XLEN itself
  localparam int unsigned CNT_W = 7;
  // number of upper bits filled when a word result is widened to XLEN
  localparam int unsigned WEXT_W = XLEN - WLEN;

  // one divide request as it arrives from the execute stage
  typedef struct packed {
    logic [XLEN-1:0] dividend;
    logic [XLEN-1:0] divisor;
    logic            is_signed;
    logic            is_word;
  } div_req_t;

  // side information that rides along with the iteration
  typedef struct packed {
    // dividend as the ISA sees it, word forms already extended
    logic [XLEN-1:0] orig_dividend;
    logic            quot_neg;
    logic            rem_neg;
    logic            div_zero;
    logic            overflow;
    logic            is_word;
  } div_meta_t;

  // conditioned operands handed to the iterative core
  typedef struct packed {
    logic [XLEN-1:0] dividend_mag;
    logic [XLEN-1:0] divisor_mag;
    div_meta_t       meta;
  } div_opnd_t;

  // unsigned core result plus the carried side information
  typedef struct packed {
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;
    div_meta_t       meta;
  } div_raw_t;

endpackage

// File: logic/div_operand_prep.sv
`timescale 1ns/1ps

module div_operand_prep (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               div_valid_i,
  input  div_pkg::div_req_t  req_i,
  input  logic               busy_i,
  output logic               start_o,
  output div_pkg::div_opnd_t opnd_o
);

  logic [div_pkg::XLEN-1:0] dvd_ext;
  logic [div_pkg::XLEN-1:0] dsr_ext;
  logic [div_pkg::XLEN-1:0] min_ext;
  logic                     dvd_neg;
  logic                     dsr_neg;
  logic                     accept;
  div_pkg::div_opnd_t       opnd_d;

  // a strobe only counts when the core is idle and no start is pending
  assign accept = div_valid_i & ~start_o & ~busy_i;

  always_comb begin
    // word forms look only at the low half, widened by sign or zero
    if (req_i.is_word) begin
      dvd_ext = {{div_pkg::WEXT_W{req_i.is_signed & req_i.dividend[div_pkg::WLEN-1]}},
                 req_i.dividend[div_pkg::WLEN-1:0]};
      dsr_ext = {{div_pkg::WEXT_W{req_i.is_signed & req_i.divisor[div_pkg::WLEN-1]}},
                 req_i.divisor[div_pkg::WLEN-1:0]};
      // most negative word, as it reads after sign extension
      min_ext = {{div_pkg::WEXT_W{1'b1}}, 1'b1, {(div_pkg::WLEN-1){1'b0}}};
    end else begin
      dvd_ext = req_i.dividend;
      dsr_ext = req_i.divisor;
      min_ext = {1'b1, {(div_pkg::XLEN-1){1'b0}}};
    end

    // operand signs only matter for DIV/REM forms
    dvd_neg = req_i.is_signed & dvd_ext[div_pkg::XLEN-1];
    dsr_neg = req_i.is_signed & dsr_ext[div_pkg::XLEN-1];

    // absolute values, the most negative value maps onto itself as unsigned
    opnd_d.dividend_mag = dvd_neg ? (~dvd_ext + 1'b1) : dvd_ext;
    opnd_d.divisor_mag  = dsr_neg ? (~dsr_ext + 1'b1) : dsr_ext;

    opnd_d.meta.orig_dividend = dvd_ext;
    // quotient negative when the signs differ
    opnd_d.meta.quot_neg = dvd_neg ^ dsr_neg;
    // remainder follows the dividend sign
    opnd_d.meta.rem_neg  = dvd_neg;
    opnd_d.meta.div_zero = (dsr_ext == '0);
    // signed min / -1 at the selected width
    opnd_d.meta.overflow = req_i.is_signed & (dvd_ext == min_ext) & (dsr_ext == '1);
    opnd_d.meta.is_word  = req_i.is_word;
  end

  // start is a single-cycle pulse per accepted request
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      start_o <= 1'b0;
    end else begin
      start_o <= accept;
    end
  end

  // operand payload only moves on an accepted strobe
  always_ff @(posedge clk) begin
    if (accept) begin
      opnd_o <= opnd_d;
    end
  end

endmodule

// File: logic/div_iter_core.sv
`timescale 1ns/1ps

module div_iter_core (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               start_i,
  input  div_pkg::div_opnd_t opnd_i,
  output logic               busy_o,
  output logic               done_o,
  output div_pkg::div_raw_t  raw_o
);

  // iteration in progress
  logic                       run_q;
  // one cycle after the final iteration
  logic                       done_q;
  // iterations still to go
  logic [div_pkg::CNT_W-1:0]  cnt_q;
  // partial remainder
  logic [div_pkg::XLEN-1:0]   rem_q;
  // dividend bits shift out the top, quotient bits shift in the bottom
  logic [div_pkg::XLEN-1:0]   quo_q;
  // divisor magnitude held for the whole run
  logic [div_pkg::XLEN-1:0]   dsr_q;
  div_pkg::div_meta_t         meta_q;

  logic [div_pkg::XLEN:0]     shift_rem;
  logic [div_pkg::XLEN:0]     trial;
  logic                       fits;
  logic                       load;

  // busy spans the whole run including the done cycle
  assign busy_o = run_q | done_q;
  assign done_o = done_q;

  // prep only pulses start while the core is idle
  assign load = start_i;

  always_comb begin
    // bring the next dividend bit into the partial remainder
    shift_rem = {rem_q, quo_q[div_pkg::XLEN-1]};
    // trial subtraction, one extra bit catches the borrow
    trial     = shift_rem - {1'b0, dsr_q};
    fits      = ~trial[div_pkg::XLEN];
  end

  // control state
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (load) begin
        run_q <= 1'b1;
        // word forms need only half the steps
        if (opnd_i.meta.is_word) begin
          cnt_q <= div_pkg::CNT_W'(div_pkg::WLEN);
        end else begin
          cnt_q <= div_pkg::CNT_W'(div_pkg::XLEN);
        end
      end else if (run_q) begin
        cnt_q <= cnt_q - 1'b1;
        // last step raises done for exactly one cycle
        if (cnt_q == div_pkg::CNT_W'(1)) begin
          run_q  <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // data path registers
  always_ff @(posedge clk) begin
    if (load) begin
      rem_q  <= '0;
      dsr_q  <= opnd_i.divisor_mag;
      meta_q <= opnd_i.meta;
      // word dividend sits in the upper half so its msb shifts out first
      if (opnd_i.meta.is_word) begin
        quo_q <= opnd_i.dividend_mag << div_pkg::WLEN;
      end else begin
        quo_q <= opnd_i.dividend_mag;
      end
    end else if (run_q) begin
      if (fits) begin
        // restore not needed, keep the difference
        rem_q <= trial[div_pkg::XLEN-1:0];
        quo_q <= {quo_q[div_pkg::XLEN-2:0], 1'b1};
      end else begin
        // divisor too large, keep the shifted value
        rem_q <= shift_rem[div_pkg::XLEN-1:0];
        quo_q <= {quo_q[div_pkg::XLEN-2:0], 1'b0};
      end
    end
  end

  // after the run the low bits of quo_q hold the quotient
  assign raw_o.quotient  = quo_q;
  assign raw_o.remainder = rem_q;
  assign raw_o.meta      = meta_q;

endmodule

// File: logic/div_result_fix.sv
`timescale 1ns/1ps

module div_result_fix (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     done_i,
  input  div_pkg::div_raw_t        raw_i,
  output logic [div_pkg::XLEN-1:0] div_data_o,
  output logic [div_pkg::XLEN-1:0] rem_data_o,
  output logic                     div_ready_o
);

  // signed magnitudes
  logic [div_pkg::XLEN-1:0] quo_sgn;
  logic [div_pkg::XLEN-1:0] rem_sgn;
  // after the special-case override
  logic [div_pkg::XLEN-1:0] quo_sel;
  logic [div_pkg::XLEN-1:0] rem_sel;
  // final values after word extension
  logic [div_pkg::XLEN-1:0] quo_fin;
  logic [div_pkg::XLEN-1:0] rem_fin;

  always_comb begin
    // two's complement where the sign says so
    quo_sgn = raw_i.meta.quot_neg ? (~raw_i.quotient + 1'b1) : raw_i.quotient;
    rem_sgn = raw_i.meta.rem_neg ? (~raw_i.remainder + 1'b1) : raw_i.remainder;

    // ISA rules win over the iterated result
    if (raw_i.meta.div_zero) begin
      // x / 0 gives all ones, x % 0 gives x
      quo_sel = '1;
      rem_sel = raw_i.meta.orig_dividend;
    end else if (raw_i.meta.overflow) begin
      // min / -1 gives min back, remainder zero
      quo_sel = raw_i.meta.orig_dividend;
      rem_sel = '0;
    end else begin
      quo_sel = quo_sgn;
      rem_sel = rem_sgn;
    end

    // *W forms always sign extend from bit 31, unsigned ones too
    if (raw_i.meta.is_word) begin
      quo_fin = {{div_pkg::WEXT_W{quo_sel[div_pkg::WLEN-1]}}, quo_sel[div_pkg::WLEN-1:0]};
      rem_fin = {{div_pkg::WEXT_W{rem_sel[div_pkg::WLEN-1]}}, rem_sel[div_pkg::WLEN-1:0]};
    end else begin
      quo_fin = quo_sel;
      rem_fin = rem_sel;
    end
  end

  // results hold until the next completion
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      div_data_o  <= '0;
      rem_data_o  <= '0;
      div_ready_o <= 1'b0;
    end else begin
      div_ready_o <= done_i;
      if (done_i) begin
        div_data_o <= quo_fin;
        rem_data_o <= rem_fin;
      end
    end
  end

endmodule

// File: logic/alu_div_top.sv
`timescale 1ns/1ps

module alu_div_top (
  input  logic                     clk,
  input  logic                     rst_n_i,
  // DIV/REM vs DIVU/REMU
  input  logic                     signed_valid_i,
  // word forms, operate on bits 31:0
  input  logic                     div32_valid_i,
  // rs1, dividend
  input  logic [div_pkg::XLEN-1:0] sr1_data_i,
  // rs2, divisor
  input  logic [div_pkg::XLEN-1:0] sr2_data_i,
  // single-cycle request strobe
  input  logic                     div_valid_i,
  // single-cycle completion pulse
  output logic                     div_ready_o,
  output logic [div_pkg::XLEN-1:0] div_out_o,
  output logic [div_pkg::XLEN-1:0] rem_out_o
);

  div_pkg::div_req_t  req;
  div_pkg::div_opnd_t opnd;
  div_pkg::div_raw_t  raw;
  logic               start;
  logic               busy;
  logic               done;

  // gather the execute-stage inputs into one request
  assign req.dividend  = sr1_data_i;
  assign req.divisor   = sr2_data_i;
  assign req.is_signed = signed_valid_i;
  assign req.is_word   = div32_valid_i;

  // signs, word select and special-case flags
  div_operand_prep u_div_operand_prep (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .div_valid_i (div_valid_i),
    .req_i       (req),
    .busy_i      (busy),
    .start_o     (start),
    .opnd_o      (opnd)
  );

  // one quotient bit per cycle
  div_iter_core u_div_iter_core (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .start_i (start),
    .opnd_i  (opnd),
    .busy_o  (busy),
    .done_o  (done),
    .raw_o   (raw)
  );

  // sign restore, ISA special cases, word extension
  div_result_fix u_div_result_fix (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .done_i      (done),
    .raw_i       (raw),
    .div_data_o  (div_out_o),
    .rem_data_o  (rem_out_o),
    .div_ready_o (div_ready_o)
  );

endmodule

// File: test/tb_div_vectors.svh
`ifndef TB_DIV_VECTORS_SVH
`define TB_DIV_VECTORS_SVH

// one directed case with hand-worked quotient and remainder
typedef struct packed {
  logic [div_pkg::XLEN-1:0] sr1;
  logic [div_pkg::XLEN-1:0] sr2;
  logic                     sgn;
  logic                     wrd;
  logic [div_pkg::XLEN-1:0] exp_q;
  logic [div_pkg::XLEN-1:0] exp_r;
} div_vec_t;

// directed cases in the order they are applied
div_vec_t vec_tbl[$];

function automatic void add_vec(input logic [63:0] sr1, input logic [63:0] sr2,
                                input logic sgn, input logic wrd,
                                input logic [63:0] exp_q, input logic [63:0] exp_r);
  div_vec_t v;
  v = '{sr1, sr2, sgn, wrd, exp_q, exp_r};
  vec_tbl.push_back(v);
endfunction

function automatic void fill_vectors();
  // DIVU/REMU, plain 64-bit
  add_vec(64'd100, 64'd7, 1'b0, 1'b0, 64'd14, 64'd2);
  add_vec('1, 64'd2, 1'b0, 1'b0, 64'h7FFF_FFFF_FFFF_FFFF, 64'd1);
  add_vec(64'd5, 64'd10, 1'b0, 1'b0, 64'd0, 64'd5);
  // min over all ones is no overflow when unsigned
  add_vec(64'h8000_0000_0000_0000, '1, 1'b0, 1'b0, 64'd0, 64'h8000_0000_0000_0000);
  // DIV/REM, all sign combinations truncate toward zero
  add_vec(-64'sd7, 64'd2, 1'b1, 1'b0, -64'sd3, -64'sd1);
  add_vec(64'd7, -64'sd2, 1'b1, 1'b0, -64'sd3, 64'd1);
  add_vec(-64'sd7, -64'sd2, 1'b1, 1'b0, 64'd3, -64'sd1);
  add_vec(64'd7, 64'd2, 1'b1, 1'b0, 64'd3, 64'd1);
  add_vec(64'h8000_0000_0000_0000, 64'd2, 1'b1, 1'b0, 64'hC000_0000_0000_0000, 64'd0);
  // word forms, upper operand bits are junk
  add_vec(64'hDEAD_BEEF_0000_0064, 64'h1234_5678_FFFF_FFF9, 1'b1, 1'b1, -64'sd14, 64'd2);
  add_vec(64'hFFFF_FFF9, 64'd2, 1'b1, 1'b1, -64'sd3, -64'sd1);
  // DIVUW quotient 0xfffffffe reads sign-extended
  add_vec(64'hAAAA_AAAA_FFFF_FFFE, 64'h5555_0000_0001, 1'b0, 1'b1, 64'hFFFF_FFFF_FFFF_FFFE, 64'd0);
  add_vec(64'h1_0000_0010, 64'hFFFF_FFFF_0000_0003, 1'b0, 1'b1, 64'd5, 64'd1);
  // REMUW remainder with bit 31 set
  add_vec(64'h8000_0005, 64'h9000_0000, 1'b0, 1'b1, 64'd0, 64'hFFFF_FFFF_8000_0005);
  // divide by zero, 64-bit then word
  add_vec(64'h1234, 64'd0, 1'b0, 1'b0, '1, 64'h1234);
  add_vec(-64'sd5, 64'd0, 1'b1, 1'b0, '1, -64'sd5);
  add_vec(64'h1_8000_0000, 64'hFFFF_FFFF_0000_0000, 1'b1, 1'b1, '1, 64'hFFFF_FFFF_8000_0000);
  // REMUW by zero still gives the sign-extended word
  add_vec(64'h8000_0003, 64'hABCD_0000_0000_0000, 1'b0, 1'b1, '1, 64'hFFFF_FFFF_8000_0003);
  // most negative over minus one
  add_vec(64'h8000_0000_0000_0000, '1, 1'b1, 1'b0, 64'h8000_0000_0000_0000, 64'd0);
  add_vec(64'h1234_5678_8000_0000, 64'hFFFF_FFFF, 1'b1, 1'b1, 64'hFFFF_FFFF_8000_0000, 64'd0);
endfunction

`endif

// File: test/tb_alu_div.sv
`timescale 1ns/1ps

module tb_alu_div;

  // cycles allowed for one divide to finish
  localparam int WAIT_MAX  = 200;
  // random DIVU/REMU cases
  localparam int RAND_CNT  = 40;
  // quiet window after dropped strobes, longer than a 64-bit divide
  localparam int QUIET_CYC = 100;

  logic                     clk;
  logic                     rst_n_i;
  logic                     signed_valid_i;
  logic                     div32_valid_i;
  logic                     div_valid_i;
  logic [div_pkg::XLEN-1:0] sr1_data_i;
  logic [div_pkg::XLEN-1:0] sr2_data_i;
  logic                     div_ready_o;
  logic [div_pkg::XLEN-1:0] div_out_o;
  logic [div_pkg::XLEN-1:0] rem_out_o;

  int          err_cnt;
  int          tmo_cnt;
  logic [31:0] lfsr;

  `include "tb_div_vectors.svh"

  alu_div_top dut0 (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .signed_valid_i (signed_valid_i),
    .div32_valid_i  (div32_valid_i),
    .sr1_data_i     (sr1_data_i),
    .sr2_data_i     (sr2_data_i),
    .div_valid_i    (div_valid_i),
    .div_ready_o    (div_ready_o),
    .div_out_o      (div_out_o),
    .rem_out_o      (rem_out_o)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_val(input string name, input logic [63:0] exp_v,
                           input logic [63:0] act_v);
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp_v, act_v);
    end
  endtask

  // galois lfsr, x^32+x^22+x^2+x+1, one step per bit
  function automatic logic take_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return b;
  endfunction

  // n fresh bits, first one ends up as msb
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], take_bit()};
    end
    return v;
  endfunction

  // one-cycle request strobe, sampled by the DUT at the second edge
  task automatic apply_op(input logic [63:0] a, input logic [63:0] b,
                          input logic sgn, input logic wrd);
    @(posedge clk);
    sr1_data_i     <= a;
    sr2_data_i     <= b;
    signed_valid_i <= sgn;
    div32_valid_i  <= wrd;
    div_valid_i    <= 1'b1;
    @(posedge clk);
    div_valid_i    <= 1'b0;
  endtask

  // returns in the middle of the ready cycle
  task automatic wait_ready(output logic got);
    got = 1'b0;
    for (int i = 0; i < WAIT_MAX && !got; i++) begin
      @(negedge clk);
      got = (div_ready_o === 1'b1);
    end
    if (!got) begin
      tmo_cnt++;
      $display("timeout: div_ready_o never came within %0d cycles", WAIT_MAX);
    end
  endtask

  task automatic run_check(input div_vec_t v);
    logic got;
    apply_op(v.sr1, v.sr2, v.sgn, v.wrd);
    wait_ready(got);
    if (got) begin
      check_val("div_out_o", v.exp_q, div_out_o);
      check_val("rem_out_o", v.exp_r, rem_out_o);
      // ready must drop after one cycle
      @(negedge clk);
      check_val("div_ready_o", 64'd0, {63'd0, div_ready_o});
    end
  endtask

  initial begin
    div_vec_t rv;
    logic     got;
    err_cnt        = 0;
    tmo_cnt        = 0;
    lfsr           = 32'h3059;
    rst_n_i        = 1'b0;
    div_valid_i    = 1'b0;
    signed_valid_i = 1'b0;
    div32_valid_i  = 1'b0;
    sr1_data_i     = '0;
    sr2_data_i     = '0;
    fill_vectors();
    repeat (8) @(posedge clk);
    rst_n_i <= 1'b1;

    // idle after reset
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check_val("div_ready_o", 64'd0, {63'd0, div_ready_o});
      check_val("div_out_o", 64'd0, div_out_o);
      check_val("rem_out_o", 64'd0, rem_out_o);
    end

    foreach (vec_tbl[i]) begin
      run_check(vec_tbl[i]);
    end

    // random unsigned, divisor width varies from 1 to 64 bits
    for (int i = 0; i < RAND_CNT; i++) begin
      rv.sr1 = rand_bits(64);
      rv.sr2 = rand_bits(int'(rand_bits(6)) + 1);
      if (rv.sr2 == '0) begin
        rv.sr2 = 64'd1;
      end
      rv.sgn   = 1'b0;
      rv.wrd   = 1'b0;
      rv.exp_q = rv.sr1 / rv.sr2;
      rv.exp_r = rv.sr1 % rv.sr2;
      run_check(rv);
    end

    // first strobe, sampled at the second edge
    @(posedge clk);
    sr1_data_i     <= 64'd1000;
    sr2_data_i     <= 64'd3;
    signed_valid_i <= 1'b0;
    div32_valid_i  <= 1'b0;
    div_valid_i    <= 1'b1;
    @(posedge clk);
    // second strobe lands while start is high
    sr1_data_i     <= 64'd77;
    sr2_data_i     <= 64'd5;
    signed_valid_i <= 1'b1;
    div32_valid_i  <= 1'b1;
    @(posedge clk);
    div_valid_i    <= 1'b0;
    // third strobe lands while the core is busy
    apply_op(-64'sd9, 64'd4, 1'b1, 1'b0);
    wait_ready(got);
    if (got) begin
      check_val("div_out_o", 64'd333, div_out_o);
      check_val("rem_out_o", 64'd1, rem_out_o);
    end
    // dropped strobes leave no completion behind
    for (int i = 0; i < QUIET_CYC; i++) begin
      @(negedge clk);
      check_val("div_ready_o", 64'd0, {63'd0, div_ready_o});
    end

    $display("errors: %0d, timeouts: %0d", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+test
logic/div_pkg.sv
logic/div_operand_prep.sv
logic/div_iter_core.sv
logic/div_result_fix.sv
logic/alu_div_top.sv
test/tb_alu_div.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the divider testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f compile.f \
  --top-module tb_alu_div \
  --Mdir obj_dir \
  -o tb_alu_div_sim

sim_out="$(./obj_dir/tb_alu_div_sim)"
echo "$sim_out"

if grep -q "Simulation finished: PASS" <<< "$sim_out"; then
  echo "run_sim: divider test passed"
  exit 0
fi
echo "run_sim: divider test did not pass"
exit 1
